// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu_top
RTL_TOP   ?= cpu_top
FILELIST  ?= cpu_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert
LINTFLAGS ?= --lint-only -Wall --timing
PASS_TEXT ?= STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== cpu_top.f ====
source/cpu_pkg.sv
source/cpu_alu.sv
source/cpu_regfile.sv
source/cpu_delay_timer.sv
source/cpu_control.sv
source/cpu_datapath.sv
source/cpu_top.sv
sim/cpu_checker.sv
sim/tb_cpu_top.sv

// ==== sim/cpu_cases.txt ====
// program words from @000 and one data word at @0c0
// expected stores from @100 as address wdata be on each line
// the store list ends at the first be of zero
@000
40101234 4020FFFA 70100200 70200204          // ldi r1 r2 and word stores
40400004                                     // shift amount in r4
20312000 70300208 21312000 7030020C          // add and sub
22312000 70300210 23312000 70300214          // and and or
24312000 70300218 25314000 7030021C          // xor and shl
26324000 70300220                            // shr
30512000 70500224 30511000 70500228          // two multiplies
406000A5 72600240 72600241 72600242 72600243 // byte stores on all lanes
62700301 70700250 62700303 70700254          // byte loads
60800300 70800258                            // word load
4090FFFF 40A00001 40B05A5A                   // compare operands and marker
5009A000                                     // cmp -1 with 1
81000001 70B00280 82000001 70B00284          // beq bne
83000001 70B00288 84000001 70B0028C          // blt bge
85000001 70B00290 86000001 70B00294          // bltu bgeu
80000001 70B00298                            // bra
500AA000 81000001 70B0029C 82000001 70B002A0 // cmp 1 with 1 then beq bne
500A9000 85000001 70B002A4 86000001 70B002A8 // cmp 1 with -1 then bltu bgeu
83000001 70B002AC 84000001 70B002B0          // blt bge
10000000                                     // halt
@0c0
11A23344                                     // source word for the loads
@100
00000200 00001234 f
00000204 FFFFFFFA f
00000208 0000122E f
0000020C 0000123A f
00000210 00001230 f
00000214 FFFFFFFE f
00000218 FFFFEDCE f
0000021C 00012340 f
00000220 0FFFFFFF f
00000224 FFFF92C8 f
00000228 014B5A90 f
00000240 A5000000 8
00000241 00A50000 4
00000242 0000A500 2
00000243 000000A5 1
00000250 000000A2 f
00000254 00000044 f
00000258 11A23344 f
00000280 00005A5A f
0000028C 00005A5A f
00000290 00005A5A f
000002A0 00005A5A f
000002A8 00005A5A f
000002AC 00005A5A f

// ==== sim/cpu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
    input  wire logic              clk_i,
    input  wire logic              rst_i,
    input  wire cpu_pkg::bus_req_t bus_req,
    input  wire logic              bus_ack,
    input  wire logic              halt,
    output int                     error_count,
    output int                     store_count
);

    cpu_pkg::bus_req_t exp_q [$];
    cpu_pkg::bus_req_t held_req;
    logic              held;
    logic              halt_seen;

    task automatic add_expected(input cpu_pkg::bus_req_t req);
        exp_q.push_back(req);
    endtask

    function automatic logic [31:0] lane_mask(input logic [3:0] be);
        logic [31:0] mask;
        for (int i = 0; i < 4; i++) begin
            mask[8*i +: 8] = {8{be[i]}};
        end
        return mask;
    endfunction

    task automatic compare_store(input cpu_pkg::bus_req_t got);
        cpu_pkg::bus_req_t want;
        logic [31:0]       mask;
        store_count++;
        if (exp_q.size() == 0) begin
            $display("store to %h at %0t was not expected, no stores were left", got.addr, $time);
            error_count++;
        end else begin
            want = exp_q.pop_front();
            mask = lane_mask(want.be); // only enabled lanes carry data
            if (got.addr !== want.addr) begin
                $display("ERR %0t bus_req.addr expected %h got %h", $time, want.addr, got.addr);
                error_count++;
            end
            if (got.be !== want.be) begin
                $display("ERR %0t bus_req.be expected %b got %b", $time, want.be, got.be);
                error_count++;
            end
            if ((got.wdata & mask) !== (want.wdata & mask)) begin
                $display("ERR %0t bus_req.wdata expected %h got %h", $time,
                         want.wdata & mask, got.wdata & mask);
                error_count++;
            end
        end
    endtask

    always @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            error_count = 0;
            store_count = 0;
            held        = 1'b0;
            held_req    = '0;
            halt_seen   = 1'b0;
        end else begin
            if (held && bus_req !== held_req) begin // request must hold until ack
                $display("ERR %0t bus_req expected %h got %h", $time, held_req, bus_req);
                error_count++;
            end
            if (bus_req.cyc && bus_ack && bus_req.we) begin
                compare_store(bus_req);
            end
            if (halt && bus_req.cyc) begin
                $display("a bus cycle to %h ran at %0t after the core halted", bus_req.addr, $time);
                error_count++;
            end
            if (halt && !halt_seen) begin
                halt_seen = 1'b1;
                if (exp_q.size() != 0) begin
                    $display("halt rose at %0t with %0d expected stores never seen",
                             $time, exp_q.size());
                    error_count += exp_q.size();
                end
            end
            held     = bus_req.cyc && !bus_ack;
            held_req = bus_req;
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;

    localparam int MEM_WORDS    = 256;
    localparam int CASE_WORDS   = 512;
    localparam int EXP_BASE     = 256; // expected stores start at @100
    localparam int HALT_TIMEOUT = 4000;
    localparam int QUIET_CYCLES = 20;

    logic                     clk_i;
    logic                     rst_i;
    logic [cpu_pkg::XLEN-1:0] bus_rdata;
    logic                     bus_ack;
    cpu_pkg::bus_req_t        bus_req;
    logic                     halt;

    logic [cpu_pkg::XLEN-1:0] mem [MEM_WORDS];
    logic [cpu_pkg::XLEN-1:0] case_words [CASE_WORDS];
    int unsigned              wait_left;
    logic                     busy;
    logic                     timed_out;
    int                       exp_loaded;
    int                       error_count;
    int                       store_count;

    always #5 clk_i = ~clk_i;

    cpu_top dut_i (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .bus_rdata (bus_rdata),
        .bus_ack   (bus_ack),
        .bus_req   (bus_req),
        .halt      (halt)
    );

    cpu_checker checker_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .bus_req     (bus_req),
        .bus_ack     (bus_ack),
        .halt        (halt),
        .error_count (error_count),
        .store_count (store_count)
    );

    task automatic load_cases(output int count);
        cpu_pkg::bus_req_t req;
        int                base;
        for (int i = 0; i < CASE_WORDS; i++) begin
            case_words[i] = '0;
        end
        $readmemh("sim/cpu_cases.txt", case_words);
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = case_words[i]; // program and data image
        end
        count = 0;
        base  = EXP_BASE;
        while (base + 2 < CASE_WORDS && case_words[base + 2] != '0) begin
            req       = '0;
            req.cyc   = 1'b1;
            req.we    = 1'b1;
            req.addr  = case_words[base];
            req.wdata = case_words[base + 1];
            req.be    = case_words[base + 2][3:0];
            checker_i.add_expected(req);
            count++;
            base += 3;
        end
    endtask

    task automatic serve_request();
        logic [7:0] idx;
        idx = bus_req.addr[9:2];
        if (bus_req.we) begin
            for (int i = 0; i < 4; i++) begin
                if (bus_req.be[i]) begin
                    mem[idx][8*i +: 8] = bus_req.wdata[8*i +: 8]; // be[3] is bits 31..24
                end
            end
        end else begin
            bus_rdata = mem[idx];
        end
    endtask

    task automatic wait_for_halt(input int limit, output logic expired);
        int n;
        n       = 0;
        expired = 1'b0;
        while (!halt && !expired) begin
            @(negedge clk_i);
            n++;
            if (n >= limit) begin
                expired = 1'b1;
            end
        end
    endtask

    initial begin : memory_model
        void'($urandom(32'ha0537180));
        bus_ack   = 1'b0;
        bus_rdata = '0;
        busy      = 1'b0;
        wait_left = 0;
        load_cases(exp_loaded);
        forever begin
            @(negedge clk_i);
            if (rst_i) begin
                bus_ack = 1'b0;
                busy    = 1'b0;
            end else if (bus_ack) begin
                bus_ack = 1'b0; // single-cycle ack
            end else if (bus_req.cyc) begin
                if (!busy) begin
                    busy      = 1'b1;
                    wait_left = $urandom_range(3, 0); // back-pressure
                end
                if (wait_left == 0) begin
                    serve_request();
                    bus_ack = 1'b1;
                    busy    = 1'b0;
                end else begin
                    wait_left = wait_left - 1;
                end
            end
        end
    end

    initial begin
        clk_i     = 1'b0;
        rst_i     = 1'b1;
        timed_out = 1'b0;
        repeat (2) @(negedge clk_i);
        rst_i = 1'b0;
        wait_for_halt(HALT_TIMEOUT, timed_out);
        repeat (QUIET_CYCLES) @(negedge clk_i); // bus must stay idle
        if (timed_out) begin
            $display("timeout, halt did not rise within %0d cycles", HALT_TIMEOUT);
        end
        if (exp_loaded == 0) begin
            $display("the case file holds no expected stores");
        end
        $display("stores seen %0d, expected %0d, errors %0d",
                 store_count, exp_loaded, error_count);
        if (timed_out || exp_loaded == 0 || error_count != 0) begin
            $display("STATUS: FAIL");
        end else begin
            $display("STATUS: PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/cpu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
    input  wire logic [cpu_pkg::XLEN-1:0] a,
    input  wire logic [cpu_pkg::XLEN-1:0] b,
    input  wire cpu_pkg::alu_op_t         func,
    input  wire logic                     mul_sel,
    output logic [cpu_pkg::XLEN-1:0]      result,
    output logic [2:0]                    ccr_next
);

    logic [cpu_pkg::XLEN-1:0]         alu_out;
    logic [cpu_pkg::XLEN-1:0]         product;
    logic [$clog2(cpu_pkg::XLEN)-1:0] shamt;

    assign shamt   = b[$clog2(cpu_pkg::XLEN)-1:0];
    assign product = a * b; // low word only

    always_comb begin
        case (func)
            cpu_pkg::ALU_ADD: alu_out = a + b;
            cpu_pkg::ALU_SUB: alu_out = a - b;
            cpu_pkg::ALU_AND: alu_out = a & b;
            cpu_pkg::ALU_OR:  alu_out = a | b;
            cpu_pkg::ALU_XOR: alu_out = a ^ b;
            cpu_pkg::ALU_SHL: alu_out = a << shamt;
            cpu_pkg::ALU_SHR: alu_out = a >> shamt; // logical
            default:          alu_out = a + b;
        endcase
    end

    assign result = mul_sel ? product : alu_out;

    // flags of a - b
    assign ccr_next[cpu_pkg::CCR_EQ]  = (a == b);
    assign ccr_next[cpu_pkg::CCR_LT]  = ($signed(a) < $signed(b));
    assign ccr_next[cpu_pkg::CCR_LTU] = (a < b);

endmodule

`default_nettype wire

// ==== source/cpu_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_control (
    input  wire logic             clk_i,
    input  wire logic             rst_i,
    input  wire cpu_pkg::opcode_t ir_type,
    input  wire logic [3:0]       ir_op,
    input  wire logic [2:0]       ccr,
    input  wire logic             bus_ack,
    input  wire logic             timer_done,
    output cpu_pkg::ctrl_t        ctrl,
    output logic                  timer_start,
    output logic                  halt
);

    cpu_pkg::state_t state;
    cpu_pkg::state_t state_next;
    logic            taken;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state <= cpu_pkg::S_FETCH;
        end else begin
            state <= state_next;
        end
    end

    assign halt = (state == cpu_pkg::S_HALT);

    always_comb begin
        case (cpu_pkg::cond_t'(ir_op))
            cpu_pkg::C_BRA:  taken = 1'b1;
            cpu_pkg::C_BEQ:  taken = ccr[cpu_pkg::CCR_EQ];
            cpu_pkg::C_BNE:  taken = ~ccr[cpu_pkg::CCR_EQ];
            cpu_pkg::C_BLT:  taken = ccr[cpu_pkg::CCR_LT];
            cpu_pkg::C_BGE:  taken = ~ccr[cpu_pkg::CCR_LT];
            cpu_pkg::C_BLTU: taken = ccr[cpu_pkg::CCR_LTU];
            cpu_pkg::C_BGEU: taken = ~ccr[cpu_pkg::CCR_LTU];
            default:         taken = 1'b0; // never branch
        endcase
    end

    always_comb begin
        state_next     = state;
        timer_start    = 1'b0;
        ctrl.ir_write  = 1'b0;
        ctrl.pc_sel    = cpu_pkg::PC_HOLD;
        ctrl.a_write   = 1'b0;
        ctrl.b_write   = 1'b0;
        ctrl.alu_func  = cpu_pkg::ALU_ADD;
        ctrl.alu2_sel  = cpu_pkg::ALU2_B;
        ctrl.mar_write = 1'b0;
        ctrl.mdr_sel   = cpu_pkg::MDR_HOLD;
        ctrl.reg_write = 1'b0;
        ctrl.reg_src   = cpu_pkg::REG_SRC_MDR;
        ctrl.ccr_write = 1'b0;
        ctrl.bus_cyc   = 1'b0;
        ctrl.bus_write = 1'b0;

        case (state)
            cpu_pkg::S_FETCH: begin
                ctrl.bus_cyc = 1'b1;
                if (bus_ack) begin
                    ctrl.ir_write = 1'b1; // ir <= rdata
                    ctrl.pc_sel   = cpu_pkg::PC_NEXT;
                    state_next    = cpu_pkg::S_EVAL;
                end
            end
            cpu_pkg::S_EVAL: begin
                ctrl.a_write = 1'b1; // A <= rB
                ctrl.b_write = 1'b1; // B <= rC or rA
                case (ir_type)
                    cpu_pkg::OP_NOP:    state_next = cpu_pkg::S_FETCH;
                    cpu_pkg::OP_HALT:   state_next = cpu_pkg::S_HALT;
                    cpu_pkg::OP_ALU,
                    cpu_pkg::OP_CMP,
                    cpu_pkg::OP_LDI:    state_next = cpu_pkg::S_EXEC;
                    cpu_pkg::OP_MUL: begin
                        timer_start = 1'b1;
                        state_next  = cpu_pkg::S_MUL_WAIT;
                    end
                    cpu_pkg::OP_LOAD,
                    cpu_pkg::OP_STORE:  state_next = cpu_pkg::S_ADDR;
                    cpu_pkg::OP_BRANCH: state_next = cpu_pkg::S_BRANCH;
                    default:            state_next = cpu_pkg::S_HALT; // unknown type
                endcase
            end
            cpu_pkg::S_EXEC: begin
                case (ir_type)
                    cpu_pkg::OP_ALU: begin
                        ctrl.alu_func = cpu_pkg::alu_op_t'(ir_op[2:0]);
                        ctrl.mdr_sel  = cpu_pkg::MDR_ALU;
                        state_next    = cpu_pkg::S_WRITEBACK;
                    end
                    cpu_pkg::OP_CMP: begin
                        ctrl.ccr_write = 1'b1;
                        state_next     = cpu_pkg::S_FETCH;
                    end
                    default: begin // ldi
                        ctrl.mdr_sel = cpu_pkg::MDR_IMM;
                        state_next   = cpu_pkg::S_WRITEBACK;
                    end
                endcase
            end
            cpu_pkg::S_MUL_WAIT: begin
                ctrl.alu2_sel = cpu_pkg::ALU2_MUL;
                ctrl.mdr_sel  = cpu_pkg::MDR_ALU; // product settles before done
                if (timer_done) begin
                    state_next = cpu_pkg::S_WRITEBACK;
                end
            end
            cpu_pkg::S_ADDR: begin
                ctrl.alu2_sel  = cpu_pkg::ALU2_IMM;
                ctrl.mar_write = 1'b1; // MAR <= rB + imm
                state_next     = cpu_pkg::S_MEM;
            end
            cpu_pkg::S_MEM: begin
                ctrl.bus_cyc = 1'b1;
                if (ir_type == cpu_pkg::OP_STORE) begin
                    ctrl.bus_write = 1'b1;
                end else begin
                    ctrl.mdr_sel = cpu_pkg::MDR_BUS;
                end
                if (bus_ack) begin
                    state_next = (ir_type == cpu_pkg::OP_STORE) ? cpu_pkg::S_FETCH
                                                                : cpu_pkg::S_WRITEBACK;
                end
            end
            cpu_pkg::S_WRITEBACK: begin
                ctrl.reg_write = 1'b1; // rA <= result
                if (ir_type == cpu_pkg::OP_LOAD) begin
                    ctrl.reg_src = cpu_pkg::REG_SRC_LOAD;
                end
                state_next = cpu_pkg::S_FETCH;
            end
            cpu_pkg::S_BRANCH: begin
                if (taken) begin
                    ctrl.pc_sel = cpu_pkg::PC_REL;
                end
                state_next = cpu_pkg::S_FETCH;
            end
            cpu_pkg::S_HALT: state_next = cpu_pkg::S_HALT;
            default:         state_next = cpu_pkg::S_HALT;
        endcase
    end

    // no transfer completes once halted
    a_halt_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
        halt |-> !bus_ack);

    a_mul_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        timer_start |-> ##(cpu_pkg::MUL_LATENCY) timer_done);

endmodule

`default_nettype wire

// ==== source/cpu_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_datapath (
    input  wire logic                     clk_i,
    input  wire logic                     rst_i,
    input  wire cpu_pkg::ctrl_t           ctrl,
    input  wire logic [cpu_pkg::XLEN-1:0] bus_rdata,
    input  wire logic                     bus_ack,
    output cpu_pkg::bus_req_t             bus_req,
    output cpu_pkg::opcode_t              ir_type,
    output logic [3:0]                    ir_op,
    output logic [2:0]                    ccr
);

    logic [cpu_pkg::XLEN-1:0]       pc, ir, a_q, b_q, mar, mdr;
    logic [cpu_pkg::XLEN-1:0]       imm, rd1, rd2, alu_b, alu_result;
    logic [cpu_pkg::XLEN-1:0]       lane_word, load_data, wb_data;
    logic [cpu_pkg::XLEN-1:0]       addr_q, wdata_q;
    logic [cpu_pkg::REG_ADDR_W-1:0] ra, rb, rc, rd2_addr;
    logic [2:0]                     ccr_next;
    logic [3:0]                     be_q;
    logic [4:0]                     lane_shift;
    logic                           is_byte, data_acc, launch;
    logic                           cyc_q, we_q;

    assign ir_type = cpu_pkg::opcode_t'(ir[cpu_pkg::IR_TYPE_LSB +: 4]);
    assign ir_op   = ir[cpu_pkg::IR_OP_LSB +: 4];
    assign ra      = ir[cpu_pkg::IR_RA_LSB +: cpu_pkg::REG_ADDR_W];
    assign rb      = ir[cpu_pkg::IR_RB_LSB +: cpu_pkg::REG_ADDR_W];
    assign rc      = ir[cpu_pkg::IR_RC_LSB +: cpu_pkg::REG_ADDR_W];
    assign imm     = {{(cpu_pkg::XLEN-cpu_pkg::IMM_W){ir[cpu_pkg::IMM_W-1]}},
                      ir[cpu_pkg::IMM_W-1:0]};

    assign rd2_addr = (ir_type == cpu_pkg::OP_STORE) ? ra : rc; // store data is rA

    cpu_regfile regfile_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .read_addr1 (rb),
        .read_addr2 (rd2_addr),
        .write_addr (ra),
        .write_en   (ctrl.reg_write),
        .write_data (wb_data),
        .read_data1 (rd1),
        .read_data2 (rd2)
    );

    assign alu_b = (ctrl.alu2_sel == cpu_pkg::ALU2_IMM) ? imm : b_q;

    cpu_alu alu_i (
        .a        (a_q),
        .b        (alu_b),
        .func     (ctrl.alu_func),
        .mul_sel  (ctrl.alu2_sel == cpu_pkg::ALU2_MUL),
        .result   (alu_result),
        .ccr_next (ccr_next)
    );

    // big-endian lanes, offset 0 is bits 31..24
    assign lane_shift = {~mar[1:0], 3'b000};
    assign is_byte    = (ir_op == cpu_pkg::MEM_OP_BYTE);
    assign lane_word  = mdr >> lane_shift;
    assign load_data  = is_byte ? {24'h0, lane_word[7:0]} : mdr;
    assign wb_data    = (ctrl.reg_src == cpu_pkg::REG_SRC_LOAD) ? load_data : mdr;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            pc  <= '0;
            ir  <= '0;
            ccr <= '0;
        end else begin
            if (ctrl.ir_write) begin
                ir <= bus_rdata;
            end
            case (ctrl.pc_sel)
                cpu_pkg::PC_NEXT: pc <= pc + 32'd4;
                cpu_pkg::PC_REL:  pc <= pc + {imm[cpu_pkg::XLEN-3:0], 2'b00}; // from next pc
                default:          pc <= pc;
            endcase
            if (ctrl.ccr_write) begin
                ccr <= ccr_next;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctrl.a_write) begin
            a_q <= rd1;
        end
        if (ctrl.b_write) begin
            b_q <= rd2;
        end
        if (ctrl.mar_write) begin
            mar <= alu_result;
        end
        case (ctrl.mdr_sel)
            cpu_pkg::MDR_ALU: mdr <= alu_result;
            cpu_pkg::MDR_IMM: mdr <= imm;
            cpu_pkg::MDR_BUS: if (bus_ack) mdr <= bus_rdata;
            default:          mdr <= mdr;
        endcase
    end

    // fetch uses the pc, data cycles use MAR
    assign data_acc = ctrl.bus_write || (ctrl.mdr_sel == cpu_pkg::MDR_BUS);
    assign launch   = ctrl.bus_cyc && !cyc_q;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            cyc_q <= 1'b0;
            we_q  <= 1'b0;
        end else if (cyc_q && bus_ack) begin
            cyc_q <= 1'b0;
            we_q  <= 1'b0;
        end else if (launch) begin
            cyc_q <= 1'b1;
            we_q  <= ctrl.bus_write;
        end
    end

    always_ff @(posedge clk_i) begin
        if (launch) begin // held until ack
            addr_q  <= data_acc ? mar : pc;
            be_q    <= (data_acc && is_byte) ? (4'b1000 >> mar[1:0]) : 4'b1111;
            wdata_q <= is_byte ? ({24'h0, b_q[7:0]} << lane_shift) : b_q;
        end
    end

    assign bus_req = '{cyc: cyc_q, we: we_q, addr: addr_q, be: be_q, wdata: wdata_q};

    a_word_be: assert property (@(posedge clk_i) disable iff (rst_i)
        bus_req.cyc && ir_op == cpu_pkg::MEM_OP_WORD |-> bus_req.be == 4'b1111);

endmodule

`default_nettype wire

// ==== source/cpu_delay_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_delay_timer (
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire logic start,
    output logic      done
);

    logic [cpu_pkg::TIMER_W-1:0] count;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            count <= '0;
        end else if (start) begin
            count <= cpu_pkg::MUL_LATENCY[cpu_pkg::TIMER_W-1:0];
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign done = (count == {{(cpu_pkg::TIMER_W-1){1'b0}}, 1'b1}); // last count

    a_no_restart: assert property (@(posedge clk_i) disable iff (rst_i)
        start |-> count == '0);

endmodule

`default_nettype wire

// ==== source/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int XLEN        = 32;
    localparam int REG_COUNT   = 16;
    localparam int REG_ADDR_W  = 4;
    localparam int MUL_LATENCY = 8;
    localparam int TIMER_W     = $clog2(MUL_LATENCY + 1);

    // instruction field positions
    localparam int IR_TYPE_LSB = 28;
    localparam int IR_OP_LSB   = 24;
    localparam int IR_RA_LSB   = 20;
    localparam int IR_RB_LSB   = 16;
    localparam int IR_RC_LSB   = 12;
    localparam int IMM_W       = 16;

    localparam logic [3:0] MEM_OP_WORD = 4'h0;
    localparam logic [3:0] MEM_OP_BYTE = 4'h2;

    // ccr bit positions
    localparam int CCR_EQ  = 0;
    localparam int CCR_LT  = 1;
    localparam int CCR_LTU = 2;

    typedef enum logic [3:0] {
        OP_NOP    = 4'h0,
        OP_HALT   = 4'h1,
        OP_ALU    = 4'h2,
        OP_MUL    = 4'h3,
        OP_LDI    = 4'h4,
        OP_CMP    = 4'h5,
        OP_LOAD   = 4'h6,
        OP_STORE  = 4'h7,
        OP_BRANCH = 4'h8
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'h0,
        ALU_SUB = 3'h1,
        ALU_AND = 3'h2,
        ALU_OR  = 3'h3,
        ALU_XOR = 3'h4,
        ALU_SHL = 3'h5,
        ALU_SHR = 3'h6
    } alu_op_t;

    typedef enum logic [3:0] {
        C_BRA  = 4'h0,
        C_BEQ  = 4'h1,
        C_BNE  = 4'h2,
        C_BLT  = 4'h3,
        C_BGE  = 4'h4,
        C_BLTU = 4'h5,
        C_BGEU = 4'h6
    } cond_t;

    typedef enum logic [3:0] {
        S_FETCH,
        S_EVAL,
        S_EXEC,
        S_MUL_WAIT,
        S_ADDR,
        S_MEM,
        S_WRITEBACK,
        S_BRANCH,
        S_HALT
    } state_t;

    typedef enum logic [1:0] {PC_HOLD, PC_NEXT, PC_REL} pc_sel_t;
    typedef enum logic [1:0] {ALU2_B, ALU2_IMM, ALU2_MUL} alu2_sel_t;
    typedef enum logic [1:0] {MDR_HOLD, MDR_ALU, MDR_IMM, MDR_BUS} mdr_sel_t;
    typedef enum logic {REG_SRC_MDR, REG_SRC_LOAD} reg_src_t;

    typedef struct packed {
        logic      ir_write;
        pc_sel_t   pc_sel;
        logic      a_write;
        logic      b_write;
        alu_op_t   alu_func;
        alu2_sel_t alu2_sel;
        logic      mar_write;
        mdr_sel_t  mdr_sel;
        logic      reg_write;
        reg_src_t  reg_src;
        logic      ccr_write;
        logic      bus_cyc;
        logic      bus_write;
    } ctrl_t;

    typedef struct packed {
        logic            cyc;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [3:0]      be;
        logic [XLEN-1:0] wdata;
    } bus_req_t;

endpackage

`default_nettype wire

// ==== source/cpu_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile (
    input  wire logic [cpu_pkg::REG_ADDR_W-1:0] read_addr1,
    input  wire logic [cpu_pkg::REG_ADDR_W-1:0] read_addr2,
    input  wire logic [cpu_pkg::REG_ADDR_W-1:0] write_addr,
    input  wire logic                           clk_i,
    input  wire logic                           rst_i,
    input  wire logic                           write_en,
    input  wire logic [cpu_pkg::XLEN-1:0]       write_data,
    output logic [cpu_pkg::XLEN-1:0]            read_data1,
    output logic [cpu_pkg::XLEN-1:0]            read_data2
);

    logic [cpu_pkg::XLEN-1:0] regs [cpu_pkg::REG_COUNT];

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            for (int i = 0; i < cpu_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_addr] <= write_data;
        end
    end

    assign read_data1 = regs[read_addr1];
    assign read_data2 = regs[read_addr2];

endmodule

`default_nettype wire

// ==== source/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  wire logic                     clk_i,
    input  wire logic                     rst_i,
    input  wire logic [cpu_pkg::XLEN-1:0] bus_rdata,
    input  wire logic                     bus_ack,
    output cpu_pkg::bus_req_t             bus_req,
    output logic                          halt
);

    cpu_pkg::ctrl_t   ctrl;
    cpu_pkg::opcode_t ir_type;
    logic [3:0]       ir_op;
    logic [2:0]       ccr;
    logic             timer_start;
    logic             timer_done;

    cpu_control control_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .ir_type     (ir_type),
        .ir_op       (ir_op),
        .ccr         (ccr),
        .bus_ack     (bus_ack),
        .timer_done  (timer_done),
        .ctrl        (ctrl),
        .timer_start (timer_start),
        .halt        (halt)
    );

    cpu_delay_timer timer_i (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .start (timer_start),
        .done  (timer_done)
    );

    cpu_datapath datapath_i (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .ctrl      (ctrl),
        .bus_rdata (bus_rdata),
        .bus_ack   (bus_ack),
        .bus_req   (bus_req),
        .ir_type   (ir_type),
        .ir_op     (ir_op),
        .ccr       (ccr)
    );

endmodule

`default_nettype wire
